// File: hw/cdbus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS shared package: data widths, register map,
// flag positions and the CRC-16/MODBUS step
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cdbus_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [4:0]  csr_addr_t;
    typedef logic [15:0] div_t;
    typedef logic [5:0]  buf_addr_t;
    typedef logic [6:0]  len_t;
    typedef logic [15:0] crc_t;

    localparam csr_addr_t reg_version  = 5'd0;
    localparam csr_addr_t reg_idle_len = 5'd2;
    localparam csr_addr_t reg_div_l    = 5'd3;
    localparam csr_addr_t reg_div_h    = 5'd4;
    localparam csr_addr_t reg_filter   = 5'd5;
    localparam csr_addr_t reg_int_mask = 5'd6;
    localparam csr_addr_t reg_int_flag = 5'd7;
    localparam csr_addr_t reg_rx_data  = 5'd8;
    localparam csr_addr_t reg_tx_data  = 5'd9;
    localparam csr_addr_t reg_rx_ctrl  = 5'd10;
    localparam csr_addr_t reg_tx_ctrl  = 5'd11;
    localparam csr_addr_t reg_rx_len   = 5'd12;

    localparam int flag_bus_idle   = 0;
    localparam int flag_rx_pending = 1;
    localparam int flag_rx_lost    = 2;
    localparam int flag_rx_error   = 3;
    localparam int flag_tx_free    = 4;

    localparam byte_t version_id     = 8'h01;
    localparam crc_t  crc_init       = 16'hffff;
    localparam crc_t  crc_poly       = 16'ha001; // Reflected form of 8005
    localparam byte_t broadcast_addr = 8'hff;
    localparam int    max_payload    = 60;
    localparam div_t  div_reset      = 16'd346; // 115200 baud at 40 MHz
    localparam byte_t idle_len_reset = 8'd10;
    localparam byte_t filter_reset   = 8'h00;

    // One byte of CRC-16/MODBUS, LSB first
    function automatic crc_t crc_update(crc_t crc, byte_t data);
        crc_t c;
        c = crc ^ crc_t'(data);
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: hw/cdbus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS internal links: configuration, byte handshake, frame buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
interface cfg_if import cdbus_pkg::*; ();
    div_t  div;
    byte_t idle_len;
    byte_t filter;

    modport csr (output div, idle_len, filter);
    modport des (input div, idle_len);
    modport ser (input div);
    modport rxf (input filter);
endinterface

interface byte_if import cdbus_pkg::*; ();
    byte_t data;
    logic  valid;
    logic  ack;
    logic  last;

    modport src (output data, valid, last, input ack);
    modport dst (input data, valid, last, output ack);
endinterface

interface buf_if import cdbus_pkg::*; ();
    byte_t     wr_byte;
    buf_addr_t wr_addr;
    logic      wr_en;
    len_t      wr_len;
    logic      commit;
    buf_addr_t rd_addr;
    byte_t     rd_byte;
    logic      rd_done;
    logic      unread;
    len_t      len;

    modport writer (output wr_byte, wr_addr, wr_en, wr_len, commit, input unread);
    modport reader (output rd_addr, rd_done, input rd_byte, unread, len);
    modport mem (input wr_byte, wr_addr, wr_en, wr_len, commit, rd_addr, rd_done,
                 output rd_byte, unread, len);
endinterface

// File: hw/cd_csr.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS register block: configuration, flags, irq
// and host access to the tx and rx frame buffers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_csr import cdbus_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t csr_address,
    input  logic      csr_read,
    input  logic      csr_write,
    input  byte_t     csr_writedata,
    output byte_t     csr_readdata,
    output logic      irq,
    input  logic      bus_idle,
    input  logic      crc_error,
    input  logic      buf_lost,
    cfg_if.csr        cfg,
    buf_if.writer     tx_buf,
    buf_if.reader     rx_buf
);
    div_t      div;
    byte_t     idle_len, filter, int_mask, flags;
    len_t      tx_cnt;
    buf_addr_t rx_ptr;
    logic      rx_lost, rx_error;

    assign cfg.div      = div;
    assign cfg.idle_len = idle_len;
    assign cfg.filter   = filter;

    assign tx_buf.wr_byte = csr_writedata;
    assign tx_buf.wr_addr = tx_cnt[5:0];
    assign tx_buf.wr_len  = tx_cnt;
    assign tx_buf.wr_en   = csr_write && csr_address == reg_tx_data
                            && !tx_buf.unread && !tx_cnt[6]; // Full at 64 bytes
    assign tx_buf.commit  = csr_write && csr_address == reg_tx_ctrl && csr_writedata[0];

    assign rx_buf.rd_addr = rx_ptr;
    assign rx_buf.rd_done = csr_write && csr_address == reg_rx_ctrl && csr_writedata[0];

    always_comb begin
        flags                  = '0;
        flags[flag_bus_idle]   = bus_idle;
        flags[flag_rx_pending] = rx_buf.unread;
        flags[flag_rx_lost]    = rx_lost;
        flags[flag_rx_error]   = rx_error;
        flags[flag_tx_free]    = !tx_buf.unread;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div      <= div_reset;
            idle_len <= idle_len_reset;
            filter   <= filter_reset;
            int_mask <= '0;
            tx_cnt   <= '0;
            rx_ptr   <= '0;
            rx_lost  <= 1'b0;
            rx_error <= 1'b0;
            irq      <= 1'b0;
        end else begin
            irq <= |(flags & int_mask);
            if (csr_write) begin
                case (csr_address)
                    reg_idle_len: idle_len  <= csr_writedata;
                    reg_div_l:    div[7:0]  <= csr_writedata;
                    reg_div_h:    div[15:8] <= csr_writedata;
                    reg_filter:   filter    <= csr_writedata;
                    reg_int_mask: int_mask  <= csr_writedata;
                    default: ;
                endcase
            end
            if (tx_buf.wr_en) tx_cnt <= tx_cnt + 1'b1;
            if (tx_buf.commit && !tx_buf.unread) tx_cnt <= '0; // Frame handed to tx path
            if (csr_read && csr_address == reg_rx_data) rx_ptr <= rx_ptr + 1'b1;
            if (rx_buf.rd_done) begin
                rx_ptr   <= '0;
                rx_lost  <= 1'b0;
                rx_error <= 1'b0;
            end
            if (buf_lost) rx_lost <= 1'b1;
            if (crc_error) rx_error <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_read) begin
            case (csr_address)
                reg_version:  csr_readdata <= version_id;
                reg_idle_len: csr_readdata <= idle_len;
                reg_div_l:    csr_readdata <= div[7:0];
                reg_div_h:    csr_readdata <= div[15:8];
                reg_filter:   csr_readdata <= filter;
                reg_int_mask: csr_readdata <= int_mask;
                reg_int_flag: csr_readdata <= flags;
                reg_rx_data:  csr_readdata <= rx_buf.rd_byte;
                reg_rx_len:   csr_readdata <= byte_t'(rx_buf.len);
                default:      csr_readdata <= '0;
            endcase
        end
    end

endmodule

// File: hw/cd_frame_buf.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS one-frame buffer with length and unread state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_frame_buf import cdbus_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    buf_if.mem   port,
    output logic lost
);
    byte_t mem [64];
    logic  unread;
    len_t  len;

    assign port.unread  = unread;
    assign port.len     = len;
    assign port.rd_byte = mem[port.rd_addr];

    // A held frame is protected from the writer until it is read out
    always_ff @(posedge clk) begin
        if (port.wr_en && !unread) mem[port.wr_addr] <= port.wr_byte;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            unread <= 1'b0;
            len    <= '0;
            lost   <= 1'b0;
        end else begin
            lost <= 1'b0;
            if (port.commit) begin
                if (unread) begin
                    lost <= 1'b1; // Refused, previous frame still held
                end else begin
                    unread <= 1'b1;
                    len    <= port.wr_len;
                end
            end else if (port.rd_done) begin
                unread <= 1'b0;
            end
        end
    end

endmodule

// File: hw/cd_tx_frame.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS tx framer: reads the tx buffer in order
// and appends the CRC-16 low and high bytes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_tx_frame import cdbus_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    buf_if.reader fbuf,
    byte_if.src   ser
);
    len_t idx;
    crc_t crc;
    logic in_data;

    assign in_data = idx < fbuf.len;

    assign fbuf.rd_addr = buf_addr_t'(idx);
    assign fbuf.rd_done = ser.ack && ser.last;

    assign ser.valid = fbuf.unread;
    assign ser.last  = idx == fbuf.len + len_t'(1); // CRC high byte
    assign ser.data  = in_data ? fbuf.rd_byte :
                       (idx == fbuf.len) ? crc[7:0] : crc[15:8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
            crc <= crc_init;
        end else if (ser.ack) begin
            if (ser.last) begin
                idx <= '0;
                crc <= crc_init;
            end else begin
                idx <= idx + 1'b1;
                if (in_data) crc <= crc_update(crc, fbuf.rd_byte);
            end
        end
    end

endmodule

// File: hw/cd_tx_ser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS serializer: UART bits onto tx, tx_en spans the frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_tx_ser import cdbus_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic bus_idle,
    cfg_if.ser   cfg,
    byte_if.dst  src,
    output logic tx,
    output logic tx_en
);
    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    div_t       cnt;
    logic [2:0] bit_idx;
    byte_t      shift;
    logic       last_q, bit_end, load;

    assign bit_end = cnt == cfg.div; // Counter runs free, so idle waits for a boundary
    assign load    = bit_end && src.valid &&
                     ((state == st_idle && bus_idle) || (state == st_stop && !last_q));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            shift   <= '0;
            last_q  <= 1'b0;
            tx      <= 1'b1;
            tx_en   <= 1'b0;
            src.ack <= 1'b0;
        end else begin
            src.ack <= load;
            cnt     <= bit_end ? '0 : cnt + 1'b1;
            if (load) begin
                state  <= st_start;
                shift  <= src.data;
                last_q <= src.last;
                tx     <= 1'b0;
                tx_en  <= 1'b1;
            end else if (bit_end) begin
                case (state)
                    st_start: begin
                        state   <= st_data;
                        tx      <= shift[0];
                        shift   <= shift >> 1;
                        bit_idx <= '0;
                    end
                    st_data: begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                            tx    <= 1'b1;
                        end else begin
                            tx    <= shift[0];
                            shift <= shift >> 1;
                        end
                    end
                    st_stop: begin
                        state <= st_idle; // End of frame
                        tx_en <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: hw/cd_rx_des.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS deserializer: mid-bit sampling and bus idle detection
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_rx_des import cdbus_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,
    cfg_if.des    cfg,
    output byte_t des_byte,
    output logic  des_strobe,
    output logic  bus_idle
);
    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t     state;
    logic [1:0] sync;
    div_t       cnt, idle_tick;
    logic [2:0] bit_idx;
    byte_t      shift, idle_cnt;
    logic       rx_s, mid, got;

    assign rx_s     = sync[1];
    assign mid      = (state == st_start) ? cnt == (cfg.div >> 1) : cnt == cfg.div;
    assign bus_idle = idle_cnt >= cfg.idle_len;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync       <= 2'b11;
            state      <= st_idle;
            cnt        <= '0;
            bit_idx    <= '0;
            shift      <= '0;
            got        <= 1'b0;
            des_strobe <= 1'b0;
            idle_tick  <= '0;
            idle_cnt   <= '0;
        end else begin
            sync       <= {sync[0], rx};
            got        <= 1'b0;
            des_strobe <= got;
            cnt        <= (state == st_idle || mid) ? '0 : cnt + 1'b1;
            case (state)
                st_idle:  if (!rx_s) state <= st_start;
                st_start: if (mid) begin
                    state   <= rx_s ? st_idle : st_data; // Glitch if high again
                    bit_idx <= '0;
                end
                st_data:  if (mid) begin
                    shift   <= {rx_s, shift[7:1]};
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= st_stop;
                end
                st_stop:  if (mid) begin
                    got   <= rx_s; // Low stop bit drops the byte
                    state <= st_idle;
                end
                default: ;
            endcase
            if (!rx_s) begin
                idle_tick <= '0;
                idle_cnt  <= '0;
            end else if (idle_tick == cfg.div) begin
                idle_tick <= '0;
                if (idle_cnt < cfg.idle_len) idle_cnt <= idle_cnt + 1'b1;
            end else begin
                idle_tick <= idle_tick + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (got) des_byte <= shift;
    end

endmodule

// File: hw/cd_rx_frame.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS rx framer: length framing, dst filter and CRC check
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cd_rx_frame import cdbus_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t des_byte,
    input  logic  des_strobe,
    input  logic  bus_idle,
    cfg_if.rxf    cfg,
    buf_if.writer fbuf,
    output logic  crc_error
);
    len_t  cnt, flen, data_end;
    crc_t  crc;
    byte_t crc_lo;
    logic  keep, hold, idle_q;

    assign data_end = flen + len_t'(3); // Header plus payload

    assign fbuf.wr_byte = des_byte;
    assign fbuf.wr_addr = buf_addr_t'(cnt);
    assign fbuf.wr_en   = des_strobe && !hold && cnt < data_end;
    assign fbuf.wr_len  = data_end;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt         <= '0;
            flen        <= '0;
            crc         <= crc_init;
            crc_lo      <= '0;
            keep        <= 1'b0;
            hold        <= 1'b0;
            idle_q      <= 1'b0;
            fbuf.commit <= 1'b0;
            crc_error   <= 1'b0;
        end else begin
            idle_q      <= bus_idle;
            fbuf.commit <= 1'b0;
            crc_error   <= 1'b0;
            if (bus_idle && !idle_q) begin
                cnt  <= '0; // Resync on a quiet line
                hold <= 1'b0;
            end else if (des_strobe && !hold) begin
                cnt <= cnt + 1'b1;
                if (cnt < data_end) crc <= crc_update((cnt == '0) ? crc_init : crc, des_byte);
                if (cnt == len_t'(1)) keep <= des_byte == cfg.filter || des_byte == broadcast_addr;
                if (cnt == len_t'(2)) begin
                    flen <= len_t'(des_byte);
                    if (des_byte > max_payload) hold <= 1'b1; // Oversize, wait for idle
                end
                if (cnt == data_end) crc_lo <= des_byte;
                if (cnt == data_end + len_t'(1)) begin
                    cnt <= '0;
                    if ({des_byte, crc_lo} == crc) fbuf.commit <= keep;
                    else crc_error <= keep;
                end
            end
        end
    end

endmodule

// File: hw/cdbus.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS controller top: register port, tx and rx paths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cdbus import cdbus_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  csr_addr_t csr_address,
    input  logic      csr_read,
    input  logic      csr_write,
    input  byte_t     csr_writedata,
    output byte_t     csr_readdata,
    output logic      irq,
    input  logic      rx,
    output logic      tx,
    output logic      tx_en
);
    byte_t des_byte;
    logic  des_strobe, bus_idle, crc_error, rx_lost;

    cfg_if  cfg ();
    byte_if tx_bytes ();
    buf_if  tx_buf ();
    buf_if  rx_buf ();

    cd_csr u_csr (
        .clk(clk), .rst_n(rst_n),
        .csr_address(csr_address), .csr_read(csr_read), .csr_write(csr_write),
        .csr_writedata(csr_writedata), .csr_readdata(csr_readdata), .irq(irq),
        .bus_idle(bus_idle), .crc_error(crc_error), .buf_lost(rx_lost),
        .cfg(cfg.csr), .tx_buf(tx_buf.writer), .rx_buf(rx_buf.reader)
    );

    cd_frame_buf u_tx_buf (.clk(clk), .rst_n(rst_n), .port(tx_buf.mem), .lost());
    cd_frame_buf u_rx_buf (.clk(clk), .rst_n(rst_n), .port(rx_buf.mem), .lost(rx_lost));

    cd_tx_frame u_tx_frame (.clk(clk), .rst_n(rst_n), .fbuf(tx_buf.reader), .ser(tx_bytes.src));

    cd_tx_ser u_tx_ser (
        .clk(clk), .rst_n(rst_n), .bus_idle(bus_idle),
        .cfg(cfg.ser), .src(tx_bytes.dst), .tx(tx), .tx_en(tx_en)
    );

    cd_rx_des u_rx_des (
        .clk(clk), .rst_n(rst_n), .rx(rx), .cfg(cfg.des),
        .des_byte(des_byte), .des_strobe(des_strobe), .bus_idle(bus_idle)
    );

    cd_rx_frame u_rx_frame (
        .clk(clk), .rst_n(rst_n), .des_byte(des_byte), .des_strobe(des_strobe),
        .bus_idle(bus_idle), .cfg(cfg.rxf), .fbuf(rx_buf.writer), .crc_error(crc_error)
    );

endmodule

// File: test/cdbus_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS protocol checks on the top-level ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cdbus_chk (
    input logic clk,
    input logic rst_n,
    input logic csr_read,
    input logic csr_write,
    input logic irq,
    input logic tx,
    input logic tx_en
);
    int assert_fails = 0;

    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_en |-> tx)
        else begin
            assert_fails++;
            $error("tx is low outside a frame");
        end

    irq_reset_low: assert property (@(posedge clk) !rst_n |=> !irq)
        else begin
            assert_fails++;
            $error("irq is high during reset");
        end

    csr_one_strobe: assert property (@(posedge clk) !(csr_read && csr_write))
        else begin
            assert_fails++;
            $error("csr_read and csr_write are high together");
        end

endmodule

bind cdbus cdbus_chk u_chk (.*);

// File: test/cdbus_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CDBUS testbench: directed tests over loopback
// and a bit-banged receive line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cdbus_tb import cdbus_pkg::*; ();
    localparam int    bit_clks  = 4; // Bit period with div set to 3
    localparam byte_t node_addr = 8'h42;
    // Bytes of all frames in the run at 40 clocks each, plus register traffic and idle gaps
    localparam int    timeout_cycles = (13 + 9 + 9 + 10 + 8 + 10 + 7) * 40 + 3000;

    logic      clk, rst_n, csr_read, csr_write, rx, line_drv, irq, tx, tx_en;
    csr_addr_t csr_address;
    byte_t     csr_writedata, csr_readdata;
    byte_t     frame_mem [64];
    byte_t     held_mem [64];
    int        frame_n, held_n, errors, cycles;
    integer    seed;

    assign rx = tx_en ? tx : line_drv; // Own frames loop back onto the receiver

    cdbus UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("** FAIL **");
        $finish;
    end

    task automatic csr_wr(input csr_addr_t addr, input byte_t data);
        csr_address   = addr;
        csr_writedata = data;
        csr_write     = 1'b1;
        @(negedge clk);
        csr_write = 1'b0;
    endtask

    task automatic csr_rd(input csr_addr_t addr, output byte_t data);
        csr_address = addr;
        csr_read    = 1'b1;
        @(negedge clk);
        csr_read = 1'b0;
        data     = csr_readdata;
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_clocks(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s = %0d clocks, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input int pos, input logic exp);
        byte_t f;
        csr_rd(reg_int_flag, f);
        check_bit(name, f[pos], exp);
    endtask

    // Polls the flag register until the flag rises
    task automatic wait_flag(input string name, input int pos);
        byte_t f;
        int    n;
        f = '0;
        n = 0;
        while (!f[pos] && n < 64) begin
            csr_rd(reg_int_flag, f);
            n++;
        end
        if (!f[pos]) begin
            errors++;
            $display("Flag %s never rose after the frame", name);
        end
    endtask

    task automatic build_frame(input byte_t src, input byte_t dst, input int n);
        frame_mem[0] = src;
        frame_mem[1] = dst;
        frame_mem[2] = byte_t'(n);
        for (int i = 0; i < n; i++) frame_mem[3 + i] = byte_t'($random(seed));
        frame_n = n + 3;
    endtask

    // CRC-16/MODBUS over the frame, one bit at a time
    function automatic crc_t frame_crc();
        crc_t c;
        logic fb;
        c = 16'hffff;
        for (int i = 0; i < frame_n; i++) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ frame_mem[i][b];
                c  = c >> 1;
                if (fb) c = c ^ 16'ha001;
            end
        end
        return c;
    endfunction

    // Line level of bit j of the whole frame, CRC low byte first
    function automatic logic frame_bit_level(input int j, input crc_t crc);
        byte_t b;
        int    m, pos;
        m   = j / 10;
        pos = j % 10;
        if (m < frame_n) b = frame_mem[m];
        else if (m == frame_n) b = crc[7:0];
        else b = crc[15:8];
        if (pos == 0) return 1'b0;
        if (pos == 9 || m > frame_n + 1) return 1'b1;
        return b[pos - 1];
    endfunction

    task automatic line_bit(input logic v);
        line_drv = v;
        repeat (bit_clks) @(negedge clk);
    endtask

    task automatic line_byte(input byte_t b);
        line_bit(1'b0);
        for (int i = 0; i < 8; i++) line_bit(b[i]);
        line_bit(1'b1);
    endtask

    task automatic send_frame_bits(input logic bad_crc);
        crc_t crc;
        crc = frame_crc();
        if (bad_crc) crc[0] = ~crc[0];
        repeat (14 * bit_clks) @(negedge clk); // Long enough for bus_idle to rise
        for (int i = 0; i < frame_n; i++) line_byte(frame_mem[i]);
        line_byte(crc[7:0]);
        line_byte(crc[15:8]);
        repeat (3 * bit_clks) @(negedge clk);
    endtask

    task automatic check_rx_frame();
        byte_t d;
        csr_rd(reg_rx_len, d);
        check_len("rx_len", len_t'(d), len_t'(frame_n));
        for (int i = 0; i < frame_n; i++) begin
            csr_rd(reg_rx_data, d);
            check_byte($sformatf("rx_data[%0d]", i), d, frame_mem[i]);
        end
    endtask

    task automatic test_reset_regs();
        byte_t d;
        csr_rd(reg_version, d);
        check_byte("version", d, 8'h01);
        csr_wr(reg_idle_len, 8'd12);
        csr_wr(reg_filter, node_addr);
        csr_rd(reg_idle_len, d);
        check_byte("idle_len", d, 8'd12);
        csr_rd(reg_div_l, d);
        check_byte("div_l", d, 8'h03);
        csr_rd(reg_div_h, d);
        check_byte("div_h", d, 8'h00);
        csr_rd(reg_filter, d);
        check_byte("filter", d, node_addr);
        check_flag("tx_free", flag_tx_free, 1'b1);
        check_flag("rx_pending", flag_rx_pending, 1'b0);
        check_bit("irq", irq, 1'b0);
    endtask

    task automatic test_loopback();
        crc_t crc;
        int   n;
        build_frame(8'h11, node_addr, 8);
        crc = frame_crc();
        for (int i = 0; i < frame_n; i++) csr_wr(reg_tx_data, frame_mem[i]);
        csr_wr(reg_tx_ctrl, 8'h01);
        while (!tx_en) @(negedge clk);
        check_flag("tx_free", flag_tx_free, 1'b0);
        n = 1;
        while (tx_en) begin
            if (n % bit_clks == 2) begin // Middle of a bit period
                check_bit($sformatf("tx bit %0d", n / bit_clks), tx,
                          frame_bit_level(n / bit_clks, crc));
            end
            @(negedge clk);
            n++;
        end
        check_clocks("tx_en width", n, (frame_n + 2) * 10 * bit_clks);
        wait_flag("rx_pending", flag_rx_pending);
        check_rx_frame();
        csr_wr(reg_rx_ctrl, 8'h01);
        check_flag("tx_free", flag_tx_free, 1'b1);
    endtask

    task automatic test_filter();
        build_frame(8'h21, 8'h43, 4);
        send_frame_bits(1'b0);
        check_flag("rx_pending", flag_rx_pending, 1'b0);
        check_flag("rx_error", flag_rx_error, 1'b0);
        build_frame(8'h21, 8'hff, 4);
        send_frame_bits(1'b0);
        wait_flag("rx_pending", flag_rx_pending);
        check_rx_frame();
        csr_wr(reg_rx_ctrl, 8'h01);
    endtask

    task automatic test_crc_error();
        build_frame(8'h31, node_addr, 5);
        send_frame_bits(1'b1);
        check_flag("rx_error", flag_rx_error, 1'b1);
        check_flag("rx_pending", flag_rx_pending, 1'b0);
        csr_wr(reg_rx_ctrl, 8'h01);
        check_flag("rx_error", flag_rx_error, 1'b0);
    endtask

    task automatic test_overrun();
        build_frame(8'h41, node_addr, 3);
        send_frame_bits(1'b0);
        wait_flag("rx_pending", flag_rx_pending);
        for (int i = 0; i < frame_n; i++) held_mem[i] = frame_mem[i];
        held_n = frame_n;
        build_frame(8'h42, node_addr, 5);
        send_frame_bits(1'b0);
        check_flag("rx_lost", flag_rx_lost, 1'b1);
        for (int i = 0; i < held_n; i++) frame_mem[i] = held_mem[i];
        frame_n = held_n;
        check_rx_frame(); // First frame must survive the refused one
        csr_wr(reg_rx_ctrl, 8'h01);
        check_flag("rx_lost", flag_rx_lost, 1'b0);
    endtask

    task automatic test_irq_mask();
        csr_wr(reg_int_mask, 8'h00);
        build_frame(8'h51, node_addr, 2);
        send_frame_bits(1'b0);
        wait_flag("rx_pending", flag_rx_pending);
        check_bit("irq", irq, 1'b0);
        csr_wr(reg_int_mask, byte_t'(1 << flag_rx_pending));
        @(negedge clk);
        check_bit("irq", irq, 1'b1);
        csr_wr(reg_rx_ctrl, 8'h01);
        @(negedge clk);
        check_bit("irq", irq, 1'b0);
    endtask

    initial begin
        seed          = 32'h6ca5;
        errors        = 0;
        frame_n       = 0;
        held_n        = 0;
        rst_n         = 1'b0;
        csr_address   = '0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = '0;
        line_drv      = 1'b1;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        csr_wr(reg_div_h, 8'h00); // Bit counters are still below 3 here
        csr_wr(reg_div_l, 8'h03);
        test_reset_regs();
        test_loopback();
        test_filter();
        test_crc_error();
        test_overrun();
        test_irq_mask();
        $display("Done: %0d check errors, %0d assertion failures",
                 errors, UUT.u_chk.assert_fails);
        if (errors == 0 && UUT.u_chk.assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
hw/cdbus_pkg.sv
hw/cdbus_if.sv
hw/cd_csr.sv
hw/cd_frame_buf.sv
hw/cd_tx_frame.sv
hw/cd_tx_ser.sv
hw/cd_rx_des.sv
hw/cd_rx_frame.sv
hw/cdbus.sv
test/cdbus_chk.sv
test/cdbus_tb.sv
